/* list.f */
+incdir+tb
logic/ldpc_enc_pkg.sv
logic/ldpc_enc_ctrl.sv
logic/ldpc_enc_acu.sv
logic/ldpc_enc_parity.sv
logic/ldpc_enc_muxout.sv
logic/ldpc_enc_engine.sv
tb/tb_ldpc_enc.sv

/* logic/ldpc_enc_acu.sv */
//------------------------------
// ldpc encoder A*u' accumulator
// keeps the systematic words and builds the
// row syndromes from rotated input words
//------------------------------

`timescale 1ns/1ps
`default_nettype none

module ldpc_enc_acu #(
  parameter int p_dat_w = ldpc_enc_pkg::c_dat_w_default
) (
  input  logic                                     iclk,
  input  logic                                     reset,
  input  logic                                     acu_clear,
  input  logic                                     acu_write,
  input  ldpc_enc_pkg::col_idx_t                   acu_col,
  input  logic [p_dat_w-1:0]                       irdat,
  input  ldpc_enc_pkg::word_idx_t                  word_idx,
  output logic [ldpc_enc_pkg::c_mb-1:0][p_dat_w-1:0] syndrome,
  output logic [p_dat_w-1:0]                       sys_dat
);

  import ldpc_enc_pkg::*;

  logic [p_dat_w-1:0] sys_mem [c_kb];

  // left rotation, shift taken modulo the lifting size
  function automatic logic [p_dat_w-1:0] rotl(
    input logic [p_dat_w-1:0] din,
    input int                 sh
  );
    logic [2*p_dat_w-1:0] dd;
    int                   s;
    s  = sh % p_dat_w;
    dd = {din, din} << s;
    return dd[2*p_dat_w-1 -: p_dat_w];
  endfunction

  //------------------------------
  // systematic store
  //------------------------------

  always_ff @(posedge iclk) begin
    if (acu_write) begin
      sys_mem[acu_col] <= irdat;
    end
  end

  // only indices below c_kb are systematic, writer muxes the rest
  assign sys_dat = sys_mem[col_idx_t'(word_idx)];

  //------------------------------
  // syndrome accumulation
  //------------------------------

  always_ff @(posedge iclk) begin
    if (reset || acu_clear) begin
      syndrome <= '0;
    end
    else if (acu_write) begin
      for (int r = 0; r < c_mb; r++) begin
        // empty circulant leaves the row untouched
        if (c_hb_tab[r][acu_col] != -1) begin
          syndrome[r] <= syndrome[r] ^ rotl(irdat, int'(c_hb_tab[r][acu_col]));
        end
      end
    end
  end

endmodule

`default_nettype wire

/* logic/ldpc_enc_ctrl.sv */
//------------------------------
// ldpc encoder controller
// phase sequencer for one frame, generates the
// source read addresses and both buffer handshakes
//------------------------------

`timescale 1ns/1ps
`default_nettype none

module ldpc_enc_ctrl #(
  parameter int p_tag_w   = 4,
  parameter int p_raddr_w = 8
) (
  input  logic                  iclk,
  input  logic                  reset,
  // source buffer
  input  logic                  irbuf_full,
  input  logic [p_tag_w-1:0]    irtag,
  output logic                  orempty,
  output logic [p_raddr_w-1:0]  oraddr,
  // sink buffer
  input  logic                  iwbuf_empty,
  // accumulator
  output logic                  acu_clear,
  output logic                  acu_write,
  output ldpc_enc_pkg::col_idx_t acu_col,
  // parity stage
  output logic                  par_start,
  input  logic                  par_done,
  // output writer
  output logic                  out_start,
  input  logic                  out_done,
  output logic [p_tag_w-1:0]    frame_tag
);

  import ldpc_enc_pkg::*;

  typedef enum logic [1:0] {
    ph_idle,
    ph_read,
    ph_parity,
    ph_write
  } phase_t;

  phase_t   phase;
  col_idx_t rd_cnt;
  logic     rd_last;
  logic     start;

  //------------------------------
  // frame start and handshakes
  //------------------------------

  // a frame only starts when the sink can take a whole codeword
  assign start = (phase == ph_idle) && irbuf_full && iwbuf_empty;

  assign oraddr = p_raddr_w'(rd_cnt);

  // last address issued, release source buffer and kick the parity rows
  assign orempty   = rd_last;
  assign par_start = rd_last;

  // writer starts in the same cycle as the last parity row
  assign out_start = (phase == ph_parity) && par_done;

  //------------------------------
  // phase FSM
  //------------------------------

  always_ff @(posedge iclk) begin
    if (reset) begin
      phase     <= ph_idle;
      rd_cnt    <= '0;
      rd_last   <= 1'b0;
      acu_clear <= 1'b0;
      acu_write <= 1'b0;
    end
    else begin
      acu_clear <= start;
      // source buffer answers one cycle after the address
      acu_write <= (phase == ph_read);
      rd_last   <= 1'b0;
      case (phase)
        ph_idle : begin
          if (start) begin
            phase <= ph_read;
          end
        end
        ph_read : begin
          // counter wraps back to zero on the last address
          rd_cnt <= rd_cnt + 1'b1;
          if (rd_cnt == col_idx_t'(c_kb - 1)) begin
            rd_last <= 1'b1;
            phase   <= ph_parity;
          end
        end
        ph_parity : begin
          if (par_done) begin
            phase <= ph_write;
          end
        end
        ph_write : begin
          if (out_done) begin
            phase <= ph_idle;
          end
        end
        default : begin
          phase <= ph_idle;
        end
      endcase
    end
  end

  // column follows the data with the same delay as acu_write
  always_ff @(posedge iclk) begin
    acu_col <= rd_cnt;
    if (start) begin
      frame_tag <= irtag;
    end
  end

  //------------------------------
  // checks
  //------------------------------

  // buffer release is a single cycle pulse per frame
  a_orempty_pulse : assert property (
    @(posedge iclk) disable iff (reset)
    orempty |=> !orempty
  ) else $error("orempty held for more than one cycle");

  // read address only moves while the frame is being read
  a_oraddr_read : assert property (
    @(posedge iclk) disable iff (reset)
    !$stable(oraddr) |-> $past(phase == ph_read)
  ) else $error("oraddr changed outside the read phase");

endmodule

`default_nettype wire

/* logic/ldpc_enc_engine.sv */
//------------------------------
// ldpc encoder engine
// reads a frame from the source buffer, encodes
// it and writes the codeword into the sink buffer
//------------------------------

`timescale 1ns/1ps
`default_nettype none

module ldpc_enc_engine #(
  parameter int p_dat_w   = ldpc_enc_pkg::c_dat_w_default,
  parameter int p_tag_w   = 4,
  parameter int p_raddr_w = 8,
  parameter int p_waddr_w = 8
) (
  input  logic                 iclk,
  input  logic                 reset,
  // source buffer
  input  logic                 irbuf_full,
  input  logic [p_tag_w-1:0]   irtag,
  input  logic [p_dat_w-1:0]   irdat,
  output logic                 orempty,
  output logic [p_raddr_w-1:0] oraddr,
  // sink buffer
  input  logic                 iwbuf_empty,
  output logic                 owrite,
  output logic                 owfull,
  output logic [p_waddr_w-1:0] owaddr,
  output logic [p_dat_w-1:0]   owdat,
  output logic [p_tag_w-1:0]   owtag
);

  import ldpc_enc_pkg::*;

  //------------------------------
  // internal nets
  //------------------------------

  logic                          acu_clear;
  logic                          acu_write;
  col_idx_t                      acu_col;
  logic                          par_start;
  logic                          par_done;
  logic                          out_start;
  logic                          out_done;
  logic [p_tag_w-1:0]            frame_tag;
  // syndromes from A*u' to the parity rows
  logic [c_mb-1:0][p_dat_w-1:0]  syndrome;
  // codeword read-back for the writer
  word_idx_t                     word_idx;
  logic [p_dat_w-1:0]            sys_dat;
  logic [p_dat_w-1:0]            par_dat;

  //------------------------------
  // stages
  //------------------------------

  ldpc_enc_ctrl #(
    .p_tag_w   (p_tag_w),
    .p_raddr_w (p_raddr_w)
  ) u_ctrl (
    .iclk        (iclk),
    .reset       (reset),
    .irbuf_full  (irbuf_full),
    .irtag       (irtag),
    .orempty     (orempty),
    .oraddr      (oraddr),
    .iwbuf_empty (iwbuf_empty),
    .acu_clear   (acu_clear),
    .acu_write   (acu_write),
    .acu_col     (acu_col),
    .par_start   (par_start),
    .par_done    (par_done),
    .out_start   (out_start),
    .out_done    (out_done),
    .frame_tag   (frame_tag)
  );

  ldpc_enc_acu #(
    .p_dat_w (p_dat_w)
  ) u_acu (
    .iclk      (iclk),
    .reset     (reset),
    .acu_clear (acu_clear),
    .acu_write (acu_write),
    .acu_col   (acu_col),
    .irdat     (irdat),
    .word_idx  (word_idx),
    .syndrome  (syndrome),
    .sys_dat   (sys_dat)
  );

  ldpc_enc_parity #(
    .p_dat_w (p_dat_w)
  ) u_parity (
    .iclk      (iclk),
    .reset     (reset),
    .par_start (par_start),
    .syndrome  (syndrome),
    .word_idx  (word_idx),
    .par_done  (par_done),
    .par_dat   (par_dat)
  );

  ldpc_enc_muxout #(
    .p_dat_w   (p_dat_w),
    .p_tag_w   (p_tag_w),
    .p_waddr_w (p_waddr_w)
  ) u_muxout (
    .iclk      (iclk),
    .reset     (reset),
    .out_start (out_start),
    .frame_tag (frame_tag),
    .sys_dat   (sys_dat),
    .par_dat   (par_dat),
    .word_idx  (word_idx),
    .out_done  (out_done),
    .owrite    (owrite),
    .owfull    (owfull),
    .owaddr    (owaddr),
    .owdat     (owdat),
    .owtag     (owtag)
  );

endmodule

`default_nettype wire

/* logic/ldpc_enc_muxout.sv */
//------------------------------
// ldpc encoder output writer
// walks the codeword and writes systematic then
// parity words into the sink buffer
//------------------------------

`timescale 1ns/1ps
`default_nettype none

module ldpc_enc_muxout #(
  parameter int p_dat_w   = ldpc_enc_pkg::c_dat_w_default,
  parameter int p_tag_w   = 4,
  parameter int p_waddr_w = 8
) (
  input  logic                    iclk,
  input  logic                    reset,
  input  logic                    out_start,
  input  logic [p_tag_w-1:0]      frame_tag,
  input  logic [p_dat_w-1:0]      sys_dat,
  input  logic [p_dat_w-1:0]      par_dat,
  output ldpc_enc_pkg::word_idx_t word_idx,
  output logic                    out_done,
  // sink buffer
  output logic                    owrite,
  output logic                    owfull,
  output logic [p_waddr_w-1:0]    owaddr,
  output logic [p_dat_w-1:0]      owdat,
  output logic [p_tag_w-1:0]      owtag
);

  import ldpc_enc_pkg::*;

  logic      busy;
  word_idx_t cnt;
  logic      cnt_last;

  assign word_idx = cnt;
  assign cnt_last = (cnt == word_idx_t'(c_nb - 1));

  //------------------------------
  // word counter and strobes
  //------------------------------

  always_ff @(posedge iclk) begin
    if (reset) begin
      busy   <= 1'b0;
      cnt    <= '0;
      owrite <= 1'b0;
      owfull <= 1'b0;
    end
    else begin
      owrite <= busy;
      owfull <= busy && cnt_last;
      if (out_start) begin
        busy <= 1'b1;
        cnt  <= '0;
      end
      else if (busy) begin
        cnt <= cnt + 1'b1;
        if (cnt_last) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // frame done toward controller with the last write
  assign out_done = owfull;

  //------------------------------
  // payload
  //------------------------------

  always_ff @(posedge iclk) begin
    if (busy) begin
      owaddr <= p_waddr_w'(cnt);
      // systematic part first
      owdat  <= (cnt < word_idx_t'(c_kb)) ? sys_dat : par_dat;
      owtag  <= frame_tag;
    end
  end

  // sink closes a frame only on a real write
  a_owfull_write : assert property (
    @(posedge iclk) disable iff (reset)
    owfull |-> owrite
  ) else $error("owfull without owrite");

endmodule

`default_nettype wire

/* logic/ldpc_enc_parity.sv */
//------------------------------
// ldpc encoder parity stage
// dual-diagonal recursion, one parity word per cycle
//------------------------------

`timescale 1ns/1ps
`default_nettype none

module ldpc_enc_parity #(
  parameter int p_dat_w = ldpc_enc_pkg::c_dat_w_default
) (
  input  logic                                     iclk,
  input  logic                                     reset,
  input  logic                                     par_start,
  input  logic [ldpc_enc_pkg::c_mb-1:0][p_dat_w-1:0] syndrome,
  input  ldpc_enc_pkg::word_idx_t                  word_idx,
  output logic                                     par_done,
  output logic [p_dat_w-1:0]                       par_dat
);

  import ldpc_enc_pkg::*;

  logic               busy;
  row_idx_t           row;
  logic [p_dat_w-1:0] par_mem [c_mb];
  logic [p_dat_w-1:0] par_prev;
  word_idx_t          pidx;

  // row counter
  always_ff @(posedge iclk) begin
    if (reset) begin
      busy <= 1'b0;
      row  <= '0;
    end
    else if (par_start) begin
      busy <= 1'b1;
      row  <= '0;
    end
    else if (busy) begin
      row <= row + 1'b1;
      if (row == row_idx_t'(c_mb - 1)) begin
        busy <= 1'b0;
      end
    end
  end

  assign par_done = busy && (row == row_idx_t'(c_mb - 1));

  //------------------------------
  // recursion
  //------------------------------

  // first row has no previous parity word
  assign par_prev = (row == '0) ? '0 : par_mem[row - 1'b1];

  always_ff @(posedge iclk) begin
    if (busy) begin
      par_mem[row] <= par_prev ^ syndrome[row];
    end
  end

  // parity words follow the systematic ones in the codeword
  assign pidx    = word_idx - word_idx_t'(c_kb);
  assign par_dat = par_mem[row_idx_t'(pidx)];

  // controller must not restart rows mid-frame
  a_par_start_idle : assert property (
    @(posedge iclk) disable iff (reset)
    par_start |-> !busy
  ) else $error("par_start while parity rows still running");

endmodule

`default_nettype wire

/* logic/ldpc_enc_pkg.sv */
//------------------------------
// ldpc encoder package
// code dimensions, index types and the
// base-matrix shift table of the QC code
//------------------------------

`default_nettype none

package ldpc_enc_pkg;

  //------------------------------
  // code dimensions
  //------------------------------

  // information columns of the base matrix
  localparam int c_kb = 4;

  // parity rows, one parity word per row
  localparam int c_mb = 4;

  // words per codeword, systematic part first
  localparam int c_nb = c_kb + c_mb;

  // lifting size tracks the data width
  localparam int c_dat_w_default = 8;

  //------------------------------
  // index types
  //------------------------------

  typedef logic [1:0] col_idx_t;
  typedef logic [1:0] row_idx_t;
  typedef logic [2:0] word_idx_t;

  //------------------------------
  // base matrix
  //------------------------------

  // one entry of the A part
  // -1 means no circulant, otherwise a left rotation
  typedef logic signed [5:0] hb_shift_t;

  // rotations are applied modulo the lifting size,
  // so values above the data width just wrap around
  localparam hb_shift_t c_hb_tab [c_mb][c_kb] = '{
    '{  0,  5, -1, 12 },
    '{  3, -1,  7,  1 },
    '{ -1,  9,  2, 17 },
    '{  6, 14, 11, -1 }
  };

  // parity part is a plain dual diagonal:
  // identity on the main diagonal and one below it,
  // so p0 = s0 and pj = p(j-1) ^ sj

endpackage

`default_nettype wire

/* tb/tb_ldpc_enc_check.svh */
//------------------------------
// ldpc encoder testbench helpers
// lfsr stimulus, reference encoder and
// the compare tasks used by the scoreboard
//------------------------------

`ifndef TB_LDPC_ENC_CHECK_SVH
`define TB_LDPC_ENC_CHECK_SVH

//------------------------------
// stimulus
//------------------------------

// fibonacci lfsr, taps 32 22 2 1, one step per bit
function automatic logic next_lfsr_bit();
  logic fb;
  fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
  lfsr = {lfsr[30:0], fb};
  return fb;
endfunction

function automatic logic [p_dat_w-1:0] random_word();
  logic [p_dat_w-1:0] w;
  for (int i = 0; i < p_dat_w; i++)
    w[i] = next_lfsr_bit();
  return w;
endfunction

function automatic tag_t random_tag();
  tag_t t;
  for (int i = 0; i < p_tag_w; i++)
    t[i] = next_lfsr_bit();
  return t;
endfunction

//------------------------------
// reference encoder
//------------------------------

// bit i moves up to bit i+sh, wrapping at the word width
function automatic logic [p_dat_w-1:0] rotate_left(input logic [p_dat_w-1:0] w, input int sh);
  logic [p_dat_w-1:0] r;
  for (int i = 0; i < p_dat_w; i++)
    r[(i + sh) % p_dat_w] = w[i];
  return r;
endfunction

// syndromes from the shift table, then the dual-diagonal chain
function automatic cword_t ref_encode(input frame_t u);
  logic [p_dat_w-1:0] s [c_mb];
  cword_t             cw;
  int                 sh;
  for (int r = 0; r < c_mb; r++) begin
    s[r] = '0;
    for (int c = 0; c < c_kb; c++) begin
      sh = c_hb_tab[r][c];
      // negative entry is an empty block
      if (sh >= 0)
        s[r] = s[r] ^ rotate_left(u[c], sh % p_dat_w);
    end
  end
  for (int c = 0; c < c_kb; c++)
    cw[c] = u[c];
  cw[c_kb] = s[0];
  for (int j = 1; j < c_mb; j++)
    cw[c_kb + j] = cw[c_kb + j - 1] ^ s[j];
  return cw;
endfunction

//------------------------------
// compare tasks
//------------------------------

task automatic check_word(input logic [p_dat_w-1:0] got, input logic [p_dat_w-1:0] exp,
                          input string what);
  n_word_chk++;
  if (got !== exp) begin
    n_word_err++;
    $display("CHECK FAILED at time %0t: %s, got %h expected %h", $time, what, got, exp);
  end
endtask

task automatic check_tag(input tag_t got, input tag_t exp, input string what);
  n_tag_chk++;
  if (got !== exp) begin
    n_tag_err++;
    $display("CHECK FAILED at time %0t: %s, got %h expected %h", $time, what, got, exp);
  end
endtask

task automatic check_count(input int got, input int exp, input string what);
  n_cnt_chk++;
  if (got != exp) begin
    n_cnt_err++;
    $display("CHECK FAILED at time %0t: %s, got %0d expected %0d", $time, what, got, exp);
  end
endtask

`endif

/* tb/tb_ldpc_enc.sv */
//------------------------------
// ldpc encoder engine testbench
// source and sink buffer models, frame stimulus
// and codeword compare against a reference encoder
//------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_ldpc_enc;

  import ldpc_enc_pkg::*;

  localparam int p_dat_w   = c_dat_w_default;
  localparam int p_tag_w   = 4;
  localparam int p_raddr_w = 8;
  localparam int p_waddr_w = 8;

  // start edge to owfull
  localparam int c_latency     = 17;
  localparam int c_hold_cyc    = 30;
  localparam int c_num_rand    = 20;
  localparam int c_num_frames  = 1 + c_kb + c_num_rand + 1;
  localparam int c_timeout_cyc = 40 * c_num_frames + c_hold_cyc + 100;

  typedef logic [c_kb-1:0][p_dat_w-1:0] frame_t;
  typedef logic [c_nb-1:0][p_dat_w-1:0] cword_t;
  typedef logic [p_tag_w-1:0]           tag_t;

  logic                 iclk;
  logic                 reset;
  logic                 irbuf_full;
  tag_t                 irtag;
  logic [p_dat_w-1:0]   irdat;
  logic                 orempty;
  logic [p_raddr_w-1:0] oraddr;
  logic                 iwbuf_empty;
  logic                 owrite;
  logic                 owfull;
  logic [p_waddr_w-1:0] owaddr;
  logic [p_dat_w-1:0]   owdat;
  tag_t                 owtag;

  // buffer models and scoreboard
  logic [31:0] lfsr;
  frame_t      src_q[$];
  tag_t        src_tag_q[$];
  frame_t      exp_q[$];
  tag_t        exp_tag_q[$];
  int          start_q[$];
  int          start_cyc;
  frame_t      src_mem;
  int          rd_addr_q;
  cword_t      got_cw;
  tag_t        got_tag;
  logic        eng_busy;
  logic        owfull_seen;
  int          cyc;
  int          sent_cnt;
  int          done_cnt;
  int          wr_idx;
  int          rempty_in_frame;
  int          n_owrite;
  int          n_orempty;
  int          n_word_chk;
  int          n_word_err;
  int          n_tag_chk;
  int          n_tag_err;
  int          n_cnt_chk;
  int          n_cnt_err;
  int          n_misc_err;

  `include "tb_ldpc_enc_check.svh"

  ldpc_enc_engine #(
    .p_dat_w   (p_dat_w),
    .p_tag_w   (p_tag_w),
    .p_raddr_w (p_raddr_w),
    .p_waddr_w (p_waddr_w)
  ) u_ldpc_enc_engine (
    .iclk        (iclk),
    .reset       (reset),
    .irbuf_full  (irbuf_full),
    .irtag       (irtag),
    .irdat       (irdat),
    .orempty     (orempty),
    .oraddr      (oraddr),
    .iwbuf_empty (iwbuf_empty),
    .owrite      (owrite),
    .owfull      (owfull),
    .owaddr      (owaddr),
    .owdat       (owdat),
    .owtag       (owtag)
  );

  initial begin
    iclk = 1'b0;
    forever #2 iclk = ~iclk;
  end

  function automatic int total_errors();
    return n_word_err + n_tag_err + n_cnt_err + n_misc_err;
  endfunction

  //------------------------------
  // frame start tracking
  //------------------------------

  // engine busy from the start edge until the edge after owfull
  always @(posedge iclk) begin
    cyc = cyc + 1;
    if (!reset && !eng_busy && irbuf_full && iwbuf_empty) begin
      eng_busy  = 1'b1;
      start_cyc = cyc;
      start_q.push_back(cyc);
    end
    else if (eng_busy && owfull_seen) begin
      eng_busy = 1'b0;
    end
  end

  //------------------------------
  // source buffer
  //------------------------------

  // data follows the address by one cycle
  always @(negedge iclk) begin
    if (!reset) begin
      // read addresses count up from the start edge
      if (eng_busy && cyc - start_cyc < c_kb)
        check_count(int'(oraddr), cyc - start_cyc, "read address order");
      irdat     = src_mem[rd_addr_q % c_kb];
      rd_addr_q = oraddr;
      if (irbuf_full && orempty) begin
        irbuf_full = 1'b0;
      end
      else if (!irbuf_full && src_q.size() > 0) begin
        src_mem    = src_q.pop_front();
        irtag      = src_tag_q.pop_front();
        irbuf_full = 1'b1;
      end
    end
  end

  //------------------------------
  // sink buffer and compare
  //------------------------------

  task automatic close_frame();
    cword_t exp_cw;
    int     t0;
    if (exp_q.size() == 0 || start_q.size() == 0) begin
      n_misc_err++;
      $display("owfull at time %0t arrived with no frame outstanding", $time);
    end
    else begin
      exp_cw = ref_encode(exp_q.pop_front());
      t0     = start_q.pop_front();
      for (int w = 0; w < c_nb; w++)
        check_word(got_cw[w], exp_cw[w], $sformatf("frame %0d word %0d", done_cnt, w));
      check_tag(got_tag, exp_tag_q.pop_front(), $sformatf("frame %0d tag", done_cnt));
      check_count(wr_idx, c_nb, $sformatf("frame %0d words written", done_cnt));
      check_count(cyc - t0, c_latency, $sformatf("frame %0d start to owfull", done_cnt));
    end
    got_cw          = 'x;
    wr_idx          = 0;
    rempty_in_frame = 0;
    done_cnt++;
  endtask

  always @(negedge iclk) begin
    if (reset) begin
      owfull_seen = 1'b0;
    end
    else begin
      owfull_seen = owfull;
      if (orempty) begin
        n_orempty++;
        rempty_in_frame++;
      end
      if (owrite) begin
        if (wr_idx == 0)
          check_count(rempty_in_frame, 1, "orempty pulses before first write");
        check_count(int'(owaddr), wr_idx, "write address order");
        if (owaddr < c_nb)
          got_cw[owaddr] = owdat;
        got_tag = owtag;
        wr_idx++;
        n_owrite++;
      end
      if (owfull)
        close_frame();
    end
  end

  //------------------------------
  // stimulus
  //------------------------------

  task automatic queue_frame(input frame_t f, input tag_t t);
    src_q.push_back(f);
    src_tag_q.push_back(t);
    exp_q.push_back(f);
    exp_tag_q.push_back(t);
    sent_cnt++;
  endtask

  task automatic wait_frames_done();
    wait (done_cnt == sent_cnt);
    @(negedge iclk);
  endtask

  task automatic report_test(input int n, input string name, input int e0);
    $display("test %0d %s: done, %0d errors", n, name, total_errors() - e0);
  endtask

  initial begin
    frame_t f;
    int     e0;
    int     w0;
    int     r0;
    reset       = 1'b1;
    irbuf_full  = 1'b0;
    irtag       = '0;
    irdat       = '0;
    iwbuf_empty = 1'b1;
    eng_busy    = 1'b0;
    owfull_seen = 1'b0;
    got_cw      = 'x;
    lfsr        = 32'haa2f_98b8;
    repeat (4) @(negedge iclk);
    reset = 1'b0;

    e0 = total_errors();
    queue_frame('0, tag_t'(1));
    wait_frames_done();
    report_test(1, "all-zero frame", e0);

    // one set bit per column at a varying position
    e0 = total_errors();
    for (int c = 0; c < c_kb; c++) begin
      f    = '0;
      f[c] = p_dat_w'(1) << ((3 * c + 1) % p_dat_w);
      queue_frame(f, tag_t'(c + 2));
      wait_frames_done();
    end
    report_test(2, "single bit per column", e0);

    e0 = total_errors();
    for (int n = 0; n < c_num_rand; n++) begin
      for (int c = 0; c < c_kb; c++)
        f[c] = random_word();
      queue_frame(f, random_tag());
    end
    wait_frames_done();
    report_test(3, "random frames back to back", e0);

    // sink not ready so the source stays full
    e0          = total_errors();
    iwbuf_empty = 1'b0;
    for (int c = 0; c < c_kb; c++)
      f[c] = random_word();
    queue_frame(f, tag_t'(11));
    wait (irbuf_full);
    w0 = n_owrite;
    r0 = n_orempty;
    repeat (c_hold_cyc) @(negedge iclk);
    check_count(n_owrite - w0, 0, "owrite during back-pressure");
    check_count(n_orempty - r0, 0, "orempty during back-pressure");
    check_count(int'(irbuf_full), 1, "source still full after back-pressure");
    iwbuf_empty = 1'b1;
    wait_frames_done();
    report_test(4, "back-pressure", e0);

    $display("test 5 frame tags: done, %0d checks, %0d errors", n_tag_chk, n_tag_err);
    $display("test 6 handshake and latency: done, %0d checks, %0d errors",
             n_cnt_chk, n_cnt_err);
    check_count(done_cnt, c_num_frames, "frames completed");
    $display("frames %0d, checks %0d, errors %0d", done_cnt,
             n_word_chk + n_tag_chk + n_cnt_chk, total_errors());
    if (total_errors() == 0) begin
      $display("STATUS: PASS");
    end
    else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // watchdog on the edge counter
  initial begin
    wait (cyc >= c_timeout_cyc);
    $display("run stalled: limit of %0d cycles reached with %0d of %0d frames done",
             c_timeout_cyc, done_cnt, sent_cnt);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
